// File: vlog.f
source/midi_uart_pkg.sv
source/midi_rx_serial.sv
source/midi_uart_regs.sv
source/midi_key_matrix.sv
source/midi_bus_read.sv
source/midi_uart_top.sv
bench/midi_uart_assert.sv
bench/midi_uart_tb.sv

// File: Makefile
# Verilator lint, simulation and clean for the MIDI receive cartridge

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= midi_uart_tb
RTL_TOP   ?= midi_uart_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
sim: build
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/midi_uart_tb.sv
// Testbench for the MIDI cartridge receive side
// Bus and serial tasks, key matrix reference function, checking process
`default_nettype none

module midi_uart_tb
    import midi_uart_pkg::*;
();

    logic       cpu_bus;
    logic       reset;
    logic       cs;
    logic [2:0] addr;
    logic [7:0] wr_data;
    logic       wr;
    logic       rd;
    logic       inta;
    logic       midi_in;
    logic [7:0] rd_data;
    logic       irq;

    // Expected register block contents
    logic [7:0] exp_cmd;
    logic [7:0] exp_status;
    logic [7:0] exp_buf;
    logic       exp_rx_irq;
    logic       exp_tx_irq;
    logic [7:0] exp_row;
    logic [7:0] exp_vec_midi;
    logic [7:0] exp_vec_ext;
    // Good bytes in arrival order for the key model
    logic [7:0] byte_log[$];

    // Pending comparisons that the checker drains
    string      name_q[$];
    logic [7:0] got_q[$];
    logic [7:0] exp_q[$];
    string      chk_name;
    logic [7:0] chk_got;
    logic [7:0] chk_exp;

    // Stimulus scratch
    integer     seed = 91;
    logic [31:0] rnd;
    logic [7:0] status_byte;
    logic [7:0] velocity;
    logic       force_status;

    int         check_count = 0;
    int         error_count = 0;
    int         test_count = 0;
    int         base_errors = 0;

    midi_uart_top DUT (
        .cpu_bus (cpu_bus),
        .reset   (reset),
        .cs      (cs),
        .addr    (addr),
        .wr_data (wr_data),
        .wr      (wr),
        .rd      (rd),
        .inta    (inta),
        .midi_in (midi_in),
        .rd_data (rd_data),
        .irq     (irq)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #5 cpu_bus = ~cpu_bus;
    end

    // Runaway guard for the whole run
    initial begin
        repeat (200000) @(posedge cpu_bus);
        end_with_failure("simulation ran too long, stopped by the watchdog");
    end

    // Compares every queued result half a cycle after a drive
    always @(negedge cpu_bus) begin
        while (got_q.size() > 0) begin
            chk_name = name_q.pop_front();
            chk_got  = got_q.pop_front();
            chk_exp  = exp_q.pop_front();
            check_count++;
            assert (chk_got == chk_exp) else begin
                $display("error at %0t: %s is %02h, expected %02h",
                         $time, chk_name, chk_got, chk_exp);
                error_count++;
            end
        end
    end

    // Key matrix from the byte history and its row scan
    function automatic logic [7:0] expected_scan(input logic [7:0] rows);
        logic [7:0]  keys [8];
        note_state_t st;
        logic        on;
        logic [6:0]  note_num;
        logic [7:0]  b;
        logic [7:0]  scan;
        for (int r = 0; r < 8; r++) begin
            keys[r] = '1;
        end
        st       = wait_status;
        on       = 1'b0;
        note_num = '0;
        foreach (byte_log[i]) begin
            b = byte_log[i];
            if (b[7]) begin
                // Only 0x8n and 0x9n open a note stream
                if (b[6:5] == 2'b00) begin
                    on = b[4];
                    st = read_note;
                end else begin
                    st = wait_status;
                end
            end else if (st == read_note) begin
                note_num = b[6:0];
                st       = read_velocity;
            end else if (st == read_velocity) begin
                // Row from note bits 2..0 and column from bits 5..3
                // Pressed (0) only for a note-on with nonzero velocity
                keys[note_num[2:0]][note_num[5:3]] = (on && b != 8'd0) ? 1'b0 : 1'b1;
                st = read_note;
            end
        end
        scan = '1;
        for (int r = 0; r < 8; r++) begin
            if (rows[r]) begin
                scan &= keys[r];
            end
        end
        return scan;
    endfunction

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $finish;
    endtask

    // Failure that is not a wrong value, counted with the errors
    task automatic count_failure(input string why);
        $display("%s", why);
        error_count++;
    endtask

    task automatic expect_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // One-cycle write strobe taken at the second edge
    task automatic write_reg(input logic [2:0] a, input logic [7:0] value);
        @(posedge cpu_bus);
        cs      <= 1'b1;
        wr      <= 1'b1;
        addr    <= a;
        wr_data <= value;
        @(posedge cpu_bus);
        cs      <= 1'b0;
        wr      <= 1'b0;
    endtask

    // Read held for one cycle with data taken mid-cycle
    task automatic read_reg(input logic [2:0] a, output logic [7:0] value);
        @(posedge cpu_bus);
        cs   <= 1'b1;
        rd   <= 1'b1;
        addr <= a;
        @(negedge cpu_bus);
        value = rd_data;
        @(posedge cpu_bus);
        cs   <= 1'b0;
        rd   <= 1'b0;
    endtask

    // Command write plus its effect on the model
    task automatic write_cmd(input logic [7:0] value);
        write_reg(addr_cmd_stat, value);
        if (value[cmd_ir]) begin
            exp_status = '0;
            exp_buf    = '0;
            exp_rx_irq = 1'b0;
            exp_tx_irq = 1'b0;
        end else if (value[cmd_er]) begin
            exp_status[stat_oe] = 1'b0;
            exp_status[stat_fe] = 1'b0;
        end else begin
            if (!value[cmd_rxen]) begin
                exp_status[stat_rxrdy] = 1'b0;
                exp_rx_irq = 1'b0;
            end else if (value[cmd_rxie]) begin
                exp_rx_irq = exp_status[stat_rxrdy];
            end
            if (!value[cmd_txen]) begin
                exp_status[stat_txrdy] = 1'b0;
                exp_tx_irq = 1'b0;
            end else if (!exp_cmd[cmd_txen]) begin
                exp_status[stat_txrdy] = 1'b1;
                exp_tx_irq = value[cmd_txie];
            end
            exp_cmd = value;
        end
    endtask

    task automatic write_row(input logic [7:0] rows);
        write_reg(addr_keys, rows);
        exp_row = rows;
    endtask

    // One bit on the line for bit_cycles clocks
    task automatic drive_bit(input logic b);
        @(posedge cpu_bus);
        midi_in <= b;
        repeat (bit_cycles - 1) @(posedge cpu_bus);
    endtask

    // Start, 8 data bits LSB first, stop, then one idle bit
    task automatic send_byte(input logic [7:0] value, input logic good_stop);
        int   n;
        logic seen;
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(value[i]);
        end
        @(posedge cpu_bus);
        midi_in <= good_stop;
        // Receiver reports in the middle of the stop bit
        seen = 1'b0;
        for (n = 0; n < 2 * bit_cycles && !seen; n++) begin
            @(negedge cpu_bus);
            seen = DUT.rx_strobe || DUT.rx_frame_err;
        end
        if (!seen) begin
            count_failure("timeout, receiver gave no strobe for a sent byte");
        end
        @(posedge cpu_bus);
        midi_in <= 1'b1;
        repeat (bit_cycles) @(posedge cpu_bus);
        if (good_stop) begin
            byte_log.push_back(value);
        end
        if (exp_cmd[cmd_rxen]) begin
            if (!good_stop) begin
                exp_status[stat_fe] = 1'b1;
            end else if (exp_status[stat_rxrdy]) begin
                exp_status[stat_oe] = 1'b1;
            end else begin
                exp_buf = value;
                exp_status[stat_rxrdy] = 1'b1;
                if (exp_cmd[cmd_rxie]) begin
                    exp_rx_irq = 1'b1;
                end
            end
        end
    endtask

    task automatic wait_irq(input logic level);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < 64 && !seen; n++) begin
            @(negedge cpu_bus);
            seen = (irq == level);
        end
        if (!seen) begin
            count_failure("timeout, irq never reached the expected level");
        end
    endtask

    task automatic check_reg(input logic [2:0] a, input string name);
        logic [7:0] got;
        logic [7:0] exp;
        case (a)
            addr_keys: exp = expected_scan(exp_row);
            addr_data: exp = exp_buf;
            default:   exp = exp_status;
        endcase
        read_reg(a, got);
        expect_value(name, got, exp);
        // Buffer read frees it
        if (a == addr_data) begin
            exp_status[stat_rxrdy] = 1'b0;
            exp_rx_irq = 1'b0;
        end
    endtask

    task automatic check_irq();
        @(negedge cpu_bus);
        expect_value("irq", {7'b0, irq}, {7'b0, exp_rx_irq || exp_tx_irq});
    endtask

    task automatic check_ack();
        @(posedge cpu_bus);
        inta <= 1'b1;
        @(negedge cpu_bus);
        expect_value("rd_data on inta", rd_data,
                     (exp_rx_irq || exp_tx_irq) ? exp_vec_midi : exp_vec_ext);
        @(posedge cpu_bus);
        inta <= 1'b0;
    endtask

    // Each row alone and then some row groups
    task automatic check_key_rows();
        logic [7:0] row_sel;
        for (int r = 0; r < 8; r++) begin
            row_sel    = '0;
            row_sel[r] = 1'b1;
            write_row(row_sel);
            check_reg(addr_keys, "key_data");
        end
        write_row(8'hA5);
        check_reg(addr_keys, "key_data");
        write_row(8'hFF);
        check_reg(addr_keys, "key_data");
        write_row(8'h00);
        check_reg(addr_keys, "key_data");
    endtask

    task automatic finish_test(input string name);
        int n;
        for (n = 0; n < 8 && got_q.size() > 0; n++) begin
            @(posedge cpu_bus);
        end
        if (got_q.size() > 0) begin
            count_failure("checker queue still holds results at the end of a test");
        end
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - base_errors);
        base_errors = error_count;
    endtask

    initial begin
        reset        = 1'b1;
        cs           = 1'b0;
        addr         = '0;
        wr_data      = '0;
        wr           = 1'b0;
        rd           = 1'b0;
        inta         = 1'b0;
        midi_in      = 1'b1;
        exp_cmd      = '0;
        exp_status   = '0;
        exp_buf      = '0;
        exp_rx_irq   = 1'b0;
        exp_tx_irq   = 1'b0;
        exp_row      = '0;
        exp_vec_midi = '1;
        exp_vec_ext  = '1;
        force_status = 1'b1;
        repeat (4) @(posedge cpu_bus);
        reset <= 1'b0;

        // TXEN|TXIE gives TXRDY and irq
        // Clearing TXEN drops them again
        check_reg(addr_cmd_stat, "status");
        check_irq();
        write_cmd(8'h03);
        wait_irq(1'b1);
        check_reg(addr_cmd_stat, "status");
        check_irq();
        write_cmd(8'h00);
        wait_irq(1'b0);
        check_reg(addr_cmd_stat, "status");
        check_irq();
        finish_test("reset and transmit enable");

        // One byte with RXEN|RXIE and its read back
        write_cmd(8'h0C);
        send_byte(8'h5A, 1'b1);
        wait_irq(1'b1);
        check_irq();
        check_reg(addr_cmd_stat, "status");
        check_reg(addr_data, "rx_buffer");
        check_reg(addr_cmd_stat, "status");
        check_irq();
        finish_test("receive and data read");

        // Overrun keeps the first byte and ER clears OE
        // Bad stop bit sets FE
        send_byte(8'h11, 1'b1);
        send_byte(8'h22, 1'b1);
        check_reg(addr_cmd_stat, "status");
        check_reg(addr_data, "rx_buffer");
        write_cmd(8'h10);
        check_reg(addr_cmd_stat, "status");
        send_byte(8'h33, 1'b0);
        check_reg(addr_cmd_stat, "status");
        write_cmd(8'h10);
        check_reg(addr_cmd_stat, "status");
        finish_test("overrun and framing errors");

        // Random notes with running status and a control change midway
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            if (i == 8) begin
                send_byte(8'hB0, 1'b1);
                send_byte(8'h07, 1'b1);
                send_byte(8'h64, 1'b1);
                force_status = 1'b1;
            end
            if (force_status || rnd[1:0] == 2'b00) begin
                status_byte      = (rnd[3:2] == 2'b00) ? 8'h80 : 8'h90;
                status_byte[3:0] = rnd[7:4];
                send_byte(status_byte, 1'b1);
                force_status = 1'b0;
            end
            send_byte({1'b0, rnd[14:8]}, 1'b1);
            // Some zero velocities that release even on note-on
            velocity = (rnd[17:16] == 2'b00) ? 8'h00 : {1'b0, rnd[24:18]};
            send_byte(velocity, 1'b1);
        end
        check_key_rows();
        finish_test("key matrix from note messages");

        // Vector on acknowledge follows irq
        write_reg(addr_vec_midi, 8'h3C);
        exp_vec_midi = 8'h3C;
        write_reg(addr_vec_ext, 8'hC3);
        exp_vec_ext = 8'hC3;
        check_reg(addr_data, "rx_buffer");
        wait_irq(1'b0);
        check_ack();
        send_byte(8'h42, 1'b1);
        wait_irq(1'b1);
        check_ack();
        check_irq();
        finish_test("interrupt acknowledge vectors");

        // Internal reset clears the UART side but keeps the keys
        write_cmd(8'h80);
        wait_irq(1'b0);
        check_reg(addr_cmd_stat, "status");
        check_irq();
        check_reg(addr_data, "rx_buffer");
        check_key_rows();
        finish_test("internal reset");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            end_with_failure("one or more checks failed");
        end
    end

endmodule

`default_nettype wire

// File: bench/midi_uart_assert.sv
// Bound checks on the UART register block
// Interrupt enables, overrun cause, state after reset
`default_nettype none

module midi_uart_assert
    import midi_uart_pkg::*;
(
    input wire       cpu_bus,
    input wire       reset,
    input wire [7:0] cmd_reg,
    input wire [7:0] status,
    input wire       rx_strobe,
    input wire       irq
);

    // An interrupt needs at least one enable behind it
    irq_needs_enable: assert property (
        @(posedge cpu_bus) disable iff (reset)
        $rose(irq) |-> (cmd_reg[cmd_rxie] || cmd_reg[cmd_txie])
    ) else $error("irq rose with both interrupt enables clear");

    // Overrun only from a byte landing on a full buffer
    oe_needs_full_buffer: assert property (
        @(posedge cpu_bus) disable iff (reset)
        $rose(status[stat_oe]) |-> $past(rx_strobe && status[stat_rxrdy])
    ) else $error("OE set without a byte arriving on a full buffer");

    // Reset leaves no interrupt and a clean status
    clean_after_reset: assert property (
        @(posedge cpu_bus)
        reset |=> (!irq && status == 8'h00)
    ) else $error("irq or status not clear after reset");

endmodule

bind midi_uart_regs midi_uart_assert u_assert (
    .cpu_bus   (cpu_bus),
    .reset     (reset),
    .cmd_reg   (cmd_reg),
    .status    (status),
    .rx_strobe (rx_strobe),
    .irq       (irq)
);

`default_nettype wire

// File: source/midi_uart_top.sv
// MIDI cartridge receive side
// Serial receiver, register block, key decoder and read mux
`default_nettype none

module midi_uart_top (
    input  wire        cpu_bus,
    input  wire        reset,
    input  wire        cs,
    input  wire  [2:0] addr,
    input  wire  [7:0] wr_data,
    input  wire        wr,
    input  wire        rd,
    input  wire        inta,
    input  wire        midi_in,
    output logic [7:0] rd_data,
    output logic       irq
);

    // Received byte and its strobes
    logic [7:0] rx_byte;
    logic       rx_strobe;
    logic       rx_frame_err;
    // Register contents toward the read mux
    logic [7:0] status;
    logic [7:0] rx_buffer;
    logic [7:0] vec_midi;
    logic [7:0] vec_ext;
    // Key matrix row select and scan result
    logic [7:0] key_row;
    logic [7:0] key_data;
    logic       data_read;

    midi_rx_serial u_rx (
        .cpu_bus      (cpu_bus),
        .reset        (reset),
        .midi_in      (midi_in),
        .rx_byte      (rx_byte),
        .rx_strobe    (rx_strobe),
        .rx_frame_err (rx_frame_err)
    );

    midi_uart_regs u_regs (
        .cpu_bus      (cpu_bus),
        .reset        (reset),
        .cs           (cs),
        .wr           (wr),
        .addr         (addr),
        .wr_data      (wr_data),
        .rx_byte      (rx_byte),
        .rx_strobe    (rx_strobe),
        .rx_frame_err (rx_frame_err),
        .data_read    (data_read),
        .status       (status),
        .rx_buffer    (rx_buffer),
        .vec_midi     (vec_midi),
        .vec_ext      (vec_ext),
        .key_row      (key_row),
        .irq          (irq)
    );

    // Sees every byte, even those the register block drops
    midi_key_matrix u_keys (
        .cpu_bus   (cpu_bus),
        .reset     (reset),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .key_row   (key_row),
        .key_data  (key_data)
    );

    midi_bus_read u_read (
        .cs        (cs),
        .rd        (rd),
        .addr      (addr),
        .inta      (inta),
        .irq       (irq),
        .status    (status),
        .rx_buffer (rx_buffer),
        .vec_midi  (vec_midi),
        .vec_ext   (vec_ext),
        .key_data  (key_data),
        .rd_data   (rd_data),
        .data_read (data_read)
    );

endmodule

`default_nettype wire

// File: source/midi_bus_read.sv
// CPU read path
// Register read mux, interrupt vector on acknowledge, buffer-read clear
`default_nettype none

module midi_bus_read
    import midi_uart_pkg::*;
(
    input  wire        cs,
    input  wire        rd,
    input  wire  [2:0] addr,
    input  wire        inta,
    input  wire        irq,
    input  wire  [7:0] status,
    input  wire  [7:0] rx_buffer,
    input  wire  [7:0] vec_midi,
    input  wire  [7:0] vec_ext,
    input  wire  [7:0] key_data,
    output logic [7:0] rd_data,
    output logic       data_read
);

    logic reg_read;

    // Acknowledge owns the bus, register reads step aside
    assign reg_read = cs && rd && !inta;
    // Clears RXRDY each cycle the buffer is on the bus
    assign data_read = reg_read && (addr == addr_data);

    always_comb begin
        // Undriven bus floats high
        rd_data = '1;
        if (inta) begin
            // Own vector when the UART is asking
            rd_data = irq ? vec_midi : vec_ext;
        end else if (reg_read) begin
            case (addr)
                addr_keys:     rd_data = key_data;
                addr_data:     rd_data = rx_buffer;
                addr_cmd_stat: rd_data = status;
                default:       rd_data = '1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/midi_key_matrix.sv
// MIDI note-on/note-off decoder into an 8x8 key matrix
// Running status handling and the row scan seen by the CPU
`default_nettype none

module midi_key_matrix
    import midi_uart_pkg::*;
(
    input  wire        cpu_bus,
    input  wire        reset,
    input  wire  [7:0] rx_byte,
    input  wire        rx_strobe,
    input  wire  [7:0] key_row,
    output logic [7:0] key_data
);

    note_state_t     note_state;
    // Set by a note-on status, clear for note-off
    logic            note_on;
    // Only six note bits address the matrix
    logic [5:0]      note;
    // Row r, column c; 0 means pressed
    logic [7:0][7:0] key_matrix;
    logic            is_status;
    logic            is_note_status;

    assign is_status = rx_byte[7];
    // 0x8n note-off and 0x9n note-on, any channel
    assign is_note_status = is_status && (rx_byte[6:5] == 2'b00);

    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            note_state <= wait_status;
            key_matrix <= '1;
        end else if (rx_strobe) begin
            if (is_status) begin
                // Any other status byte ends the note stream
                if (is_note_status) begin
                    note_state <= read_note;
                end else begin
                    note_state <= wait_status;
                end
            end else begin
                case (note_state)
                    // Data with no note status in force
                    wait_status: ;
                    read_note: note_state <= read_velocity;
                    read_velocity: begin
                        // Zero velocity on a note-on is a release
                        key_matrix[note[2:0]][note[5:3]] <= !(note_on && rx_byte[6:0] != 7'd0);
                        // Running status, next data byte is a note again
                        note_state <= read_note;
                    end
                    default: note_state <= wait_status;
                endcase
            end
        end
    end

    // Message payload, meaningful only while the FSM says so
    always_ff @(posedge cpu_bus) begin
        if (rx_strobe) begin
            if (is_note_status) begin
                note_on <= rx_byte[4];
            end
            if (!is_status && note_state == read_note) begin
                note <= rx_byte[5:0];
            end
        end
    end

    // Row scan, selected rows are ANDed
    // No row selected reads as nothing pressed
    always_comb begin
        key_data = '1;
        for (int r = 0; r < 8; r++) begin
            if (key_row[r]) begin
                key_data &= key_matrix[r];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/midi_uart_regs.sv
// UART register block
// Command, status, receive buffer, interrupt vectors, key row select, irq
`default_nettype none

module midi_uart_regs
    import midi_uart_pkg::*;
(
    input  wire        cpu_bus,
    input  wire        reset,
    input  wire        cs,
    input  wire        wr,
    input  wire  [2:0] addr,
    input  wire  [7:0] wr_data,
    input  wire  [7:0] rx_byte,
    input  wire        rx_strobe,
    input  wire        rx_frame_err,
    input  wire        data_read,
    output logic [7:0] status,
    output logic [7:0] rx_buffer,
    output logic [7:0] vec_midi,
    output logic [7:0] vec_ext,
    output logic [7:0] key_row,
    output logic       irq
);

    logic [7:0] cmd_reg;
    // Pending receive and transmit interrupts
    logic       rx_irq;
    logic       tx_irq;
    logic       wr_en;

    assign wr_en = cs && wr;
    // Both flags are flops, so irq changes only on a clock edge
    assign irq = rx_irq || tx_irq;

    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            cmd_reg   <= '0;
            status    <= '0;
            rx_buffer <= '0;
            rx_irq    <= 1'b0;
            tx_irq    <= 1'b0;
            vec_midi  <= '1;
            vec_ext   <= '1;
            key_row   <= '0;
        end else begin
            // CPU writes
            if (wr_en) begin
                case (addr)
                    addr_keys:     key_row  <= wr_data;
                    addr_vec_midi: vec_midi <= wr_data;
                    addr_vec_ext:  vec_ext  <= wr_data;
                    addr_cmd_stat: begin
                        if (wr_data[cmd_ir]) begin
                            // Internal reset, command itself is kept
                            rx_buffer <= '0;
                            status    <= '0;
                            rx_irq    <= 1'b0;
                            tx_irq    <= 1'b0;
                        end else if (wr_data[cmd_er]) begin
                            status[stat_oe] <= 1'b0;
                            status[stat_fe] <= 1'b0;
                        end else begin
                            cmd_reg <= wr_data;
                            // Receive side
                            if (wr_data[cmd_rxen]) begin
                                // Byte already waiting raises irq at once
                                if (wr_data[cmd_rxie]) begin
                                    rx_irq <= status[stat_rxrdy];
                                end
                            end else begin
                                status[stat_rxrdy] <= 1'b0;
                                rx_irq             <= 1'b0;
                            end
                            // Transmit side, no shifter behind it
                            // Rising TXEN reports ready straight away
                            if (wr_data[cmd_txen]) begin
                                if (!cmd_reg[cmd_txen]) begin
                                    status[stat_txrdy] <= 1'b1;
                                    tx_irq             <= wr_data[cmd_txie];
                                end
                            end else begin
                                status[stat_txrdy] <= 1'b0;
                                tx_irq             <= 1'b0;
                            end
                        end
                    end
                    // Data register writes go nowhere
                    default: ;
                endcase
            end

            // Incoming bytes, only with the receiver enabled
            if (cmd_reg[cmd_rxen]) begin
                if (rx_strobe) begin
                    if (status[stat_rxrdy]) begin
                        // Buffer still full, new byte is dropped
                        status[stat_oe] <= 1'b1;
                    end else begin
                        rx_buffer          <= rx_byte;
                        status[stat_rxrdy] <= 1'b1;
                        if (cmd_reg[cmd_rxie]) begin
                            rx_irq <= 1'b1;
                        end
                    end
                end
                if (rx_frame_err) begin
                    status[stat_fe] <= 1'b1;
                end
            end

            // Reading the buffer frees it, last so it wins
            if (data_read) begin
                status[stat_rxrdy] <= 1'b0;
                rx_irq             <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/midi_rx_serial.sv
// MIDI serial receiver
// Line synchronizer, start-bit check, mid-bit data sampling, stop-bit check
`default_nettype none

module midi_rx_serial
    import midi_uart_pkg::*;
(
    input  wire        cpu_bus,
    input  wire        reset,
    input  wire        midi_in,
    output logic [7:0] rx_byte,
    output logic       rx_strobe,
    output logic       rx_frame_err
);

    // Synchronizer stages and one delayed copy for edge detect
    logic                   sync_1;
    logic                   sync_2;
    logic                   line_prev;
    rx_state_t              rx_state;
    logic [bit_timer_w-1:0] bit_timer;
    logic [2:0]             bit_idx;
    logic                   bit_due;
    logic                   start_edge;

    // Timer has run out, the line is at the middle of a bit
    assign bit_due = (bit_timer == '0);
    // Falling edge of the idle-high line
    assign start_edge = line_prev && !sync_2;

    // Line comes in asynchronous, idles high
    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            sync_1    <= 1'b1;
            sync_2    <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_1    <= midi_in;
            sync_2    <= sync_1;
            line_prev <= sync_2;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            rx_state     <= idle;
            bit_timer    <= '0;
            bit_idx      <= '0;
            rx_strobe    <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            // Strobes last one clock
            rx_strobe    <= 1'b0;
            rx_frame_err <= 1'b0;
            case (rx_state)
                idle: begin
                    // Half a bit to reach the middle of the start bit
                    if (start_edge) begin
                        bit_timer <= bit_timer_w'(bit_cycles / 2 - 1);
                        rx_state  <= start;
                    end
                end
                start: begin
                    if (!bit_due) begin
                        bit_timer <= bit_timer - 1'b1;
                    end else if (sync_2) begin
                        // Glitch, line already back high
                        rx_state <= idle;
                    end else begin
                        bit_timer <= bit_timer_w'(bit_cycles - 1);
                        bit_idx   <= '0;
                        rx_state  <= data;
                    end
                end
                data: begin
                    if (!bit_due) begin
                        bit_timer <= bit_timer - 1'b1;
                    end else begin
                        bit_timer <= bit_timer_w'(bit_cycles - 1);
                        bit_idx   <= bit_idx + 1'b1;
                        // Eighth bit taken, stop bit next
                        if (bit_idx == 3'd7) begin
                            rx_state <= stop;
                        end
                    end
                end
                stop: begin
                    if (!bit_due) begin
                        bit_timer <= bit_timer - 1'b1;
                    end else begin
                        // Good frame or framing error, never both
                        rx_strobe    <= sync_2;
                        rx_frame_err <= !sync_2;
                        rx_state     <= idle;
                    end
                end
                default: rx_state <= idle;
            endcase
        end
    end

    // Data shifts in LSB first at each data mid-bit
    // Byte stays put until the next frame starts shifting
    always_ff @(posedge cpu_bus) begin
        if (rx_state == data && bit_due) begin
            rx_byte <= {sync_2, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: source/midi_uart_pkg.sv
// Shared constants and types for the MIDI receive cartridge
// Register map, command and status bit positions, bit timing, FSM states
`default_nettype none

package midi_uart_pkg;

    // Serial bit timing
    // Clocks per MIDI bit, 16 keeps simulation short
    // A 3.58 MHz board clock at 31250 baud needs about 115
    localparam int bit_cycles = 16;
    // Bit timer width, enough to hold bit_cycles - 1
    localparam int bit_timer_w = $clog2(bit_cycles);

    // Register addresses on the low three address bits
    // Row select on write, row scan result on read
    localparam logic [2:0] addr_keys     = 3'd2;
    // Interrupt vector for the UART itself
    localparam logic [2:0] addr_vec_midi = 3'd3;
    // Interrupt vector for the external source
    localparam logic [2:0] addr_vec_ext  = 3'd4;
    // Receive buffer, transmit writes are dropped
    localparam logic [2:0] addr_data     = 3'd5;
    // Command on write, status on read
    localparam logic [2:0] addr_cmd_stat = 3'd6;

    // Command register bits
    localparam int cmd_txen = 0;
    localparam int cmd_txie = 1;
    localparam int cmd_rxen = 2;
    localparam int cmd_rxie = 3;
    // Error reset, clears OE and FE
    localparam int cmd_er   = 4;
    // Internal reset of the UART
    localparam int cmd_ir   = 7;

    // Status register bits
    localparam int stat_txrdy = 0;
    localparam int stat_rxrdy = 1;
    // Overrun, byte lost while RXRDY was still set
    localparam int stat_oe    = 4;
    // Framing, stop bit sampled low
    localparam int stat_fe    = 5;

    // Serial receiver states
    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } rx_state_t;

    // Note message decoder states
    typedef enum logic [1:0] {
        wait_status,
        read_note,
        read_velocity
    } note_state_t;

endpackage

`default_nettype wire
